/* rtl/mmu_consts.svh */
// Sizes, field positions and codes for the MMU checker; four TLB entries and four keys are fixed
`ifndef MMU_CONSTS_SVH
`define MMU_CONSTS_SVH

`define TLB_ENTRIES  4          // Fully associative entries
`define VPN_BITS     20         // Virtual page number width

`define KR_KEYS      4          // Keys in the keyring register
`define KEY_BITS     16         // Width of one key

`define ACC_VUGID    31:16      // Page owner id
`define VUGID_GRP    15:10      // Group part of a VUGID or key
`define VUGID_USR    9:0        // User part of a VUGID or key
`define ACC_OTHER    15:13      // X/W/R for everyone else
`define ACC_GROUP    12:10      // X/W/R for group members
`define ACC_USER     9:7        // X/W/R for the owner
`define ACC_KRMODE   6:4        // Keyring checking mode

// Base bits and mask bits share positions
`define BIT_NU       3
`define BIT_NX       2
`define BIT_NW       1
`define BIT_NR       0

`define KR_X         2          // Grant bits inside a 3-bit access field
`define KR_W         1
`define KR_R         0

`define SR_SUPER     30         // Supervisor mode
`define SR_ISR_A     29
`define SR_ISR_B     28
`define MMCR_EN      0          // MMU enable
`define OPM_WR       5          // Operation writes
`define OPM_RD       4          // Operation reads

`define EXC_NONE     16'h0000
`define EXC_TLBMISS  16'hA001
`define EXC_ACCESS   16'hA002

`endif

/* rtl/mmuPkg.sv */
// Vector types shared by RTL and testbench; field positions inside the words live in the consts header
`include "mmu_consts.svh"

package mmuPkg;

	// Access-mode word of one page
	//   [31:16] VUGID, group in [15:10] and user in [9:0]
	//   [15:13] other X/W/R
	//   [12:10] group X/W/R
	//   [ 9: 7] user X/W/R
	//   [ 6: 4] keyring mode
	//   [ 3: 0] NU, NX, NW, NR
	typedef logic [31:0] accMode_t;

	// Four 16-bit keys, key A lowest; a zero key is an empty slot
	typedef logic [`KR_KEYS*`KEY_BITS-1:0] keyring_t;

	// X, W, R grant, high to low
	typedef logic [2:0] krAcc_t;

	// Deny mask
	//   5 Resv, 4 Hold, both held at zero here
	//   3 NU, 2 NX, 1 NW, 0 NR
	typedef logic [5:0] noRwx_t;

	typedef logic [15:0] excCode_t;     // Exception code, zero when none

	typedef logic [`VPN_BITS-1:0] vpn_t; // Virtual page number

endpackage

/* rtl/tlbArray.sv */
// Lookup result is registered one cycle after reqValid; a load in the same cycle is not seen yet
`timescale 1ns/1ns
`include "mmu_consts.svh"

module tlbArray
(
	input  logic                               clock,
	input  logic                               rst,

	input  logic                               loadValid,
	input  logic [$clog2(`TLB_ENTRIES)-1:0]    loadIndex,
	input  mmuPkg::vpn_t                       loadVpn,
	input  mmuPkg::accMode_t                   loadAcc,

	input  logic                               reqValid,
	input  mmuPkg::vpn_t                       reqVpn,
	input  logic [7:0]                         reqOpm,
	input  mmuPkg::keyring_t                   krr,
	input  logic [63:0]                        sr,
	input  logic [63:0]                        mmcr,

	output logic                               lookValid,
	output logic                               lookHit,
	output mmuPkg::accMode_t                   lookAcc,
	output mmuPkg::keyring_t                   lookKrr,
	output logic [63:0]                        lookSr,
	output logic [63:0]                        lookMmcr,
	output logic [7:0]                         lookOpm
);

	import mmuPkg::*;

	logic [`TLB_ENTRIES-1:0] entValid;          // Entry holds a page
	vpn_t                    entVpn [`TLB_ENTRIES];
	accMode_t                entAcc [`TLB_ENTRIES];

	logic                    hitNext;
	accMode_t                accNext;

	// Load port
	always_ff @(posedge clock)
	begin
		if (rst)
			entValid <= '0;
		else if (loadValid)
			entValid[loadIndex] <= 1'b1;
	end

	always_ff @(posedge clock)
	begin
		if (loadValid)
		begin
			entVpn[loadIndex] <= loadVpn;
			entAcc[loadIndex] <= loadAcc;
		end
	end

	// Parallel compare, scanned from the top so the lowest index wins
	always_comb
	begin
		hitNext = 1'b0;
		accNext = '0;
		for (int i = `TLB_ENTRIES - 1; i >= 0; i--)
		begin
			if (entValid[i] && (entVpn[i] == reqVpn))
			begin
				hitNext = 1'b1;
				accNext = entAcc[i];
			end
		end
	end

	// Stage 1 control
	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			lookValid <= 1'b0;
			lookHit   <= 1'b0;
		end
		else
		begin
			lookValid <= reqValid;                  // One-cycle strobe
			if (reqValid)
				lookHit <= hitNext;
		end
	end

	// Request context travels with its lookup result
	always_ff @(posedge clock)
	begin
		if (reqValid)
		begin
			lookAcc  <= accNext;
			lookKrr  <= krr;
			lookSr   <= sr;
			lookMmcr <= mmcr;
			lookOpm  <= reqOpm;
		end
	end

endmodule

/* rtl/keyringMatch.sv */
// Purely combinational; empty keys never match and a user match counts only with its group
`timescale 1ns/1ns
`include "mmu_consts.svh"

module keyringMatch
(
	input  mmuPkg::accMode_t acc,
	input  mmuPkg::keyring_t krr,
	output mmuPkg::krAcc_t   krAccFl,
	output logic             krEnA
);

	logic [`KEY_BITS-1:0] vugid;
	logic [`KEY_BITS-1:0] key;
	logic                 keyEn;
	logic                 grpEq;                    // Some key shares the group
	logic                 usrEq;                    // Some key matches group and user

	assign vugid = acc[`ACC_VUGID];

	always_comb
	begin
		grpEq = 1'b0;
		usrEq = 1'b0;
		key   = '0;
		keyEn = 1'b0;
		for (int k = 0; k < `KR_KEYS; k++)
		begin
			key   = krr[k*`KEY_BITS +: `KEY_BITS];
			keyEn = (key != '0);
			if (keyEn && (key[`VUGID_GRP] == vugid[`VUGID_GRP]))
			begin
				grpEq = 1'b1;
				if (key[`VUGID_USR] == vugid[`VUGID_USR])
					usrEq = 1'b1;
			end
		end
	end

	// Most specific field wins
	always_comb
	begin
		if (usrEq)
			krAccFl = acc[`ACC_USER];
		else if (grpEq)
			krAccFl = acc[`ACC_GROUP];
		else
			krAccFl = acc[`ACC_OTHER];
	end

	// Key A present turns keyring checking on
	assign krEnA = (krr[`KEY_BITS-1:0] != '0);

endmodule

/* rtl/accessCheck.sv */
// Result registered one cycle after lookValid; an exception always comes with a zero mask
`timescale 1ns/1ns
`include "mmu_consts.svh"

module accessCheck
(
	input  logic             clock,
	input  logic             rst,

	input  logic             lookValid,
	input  logic             lookHit,
	input  mmuPkg::accMode_t lookAcc,
	input  logic [63:0]      lookSr,
	input  logic [63:0]      lookMmcr,
	input  logic [7:0]       lookOpm,
	input  mmuPkg::krAcc_t   krAccFl,
	input  logic             krEnA,

	output logic             respValid,
	output mmuPkg::noRwx_t   respNoRwx,
	output mmuPkg::excCode_t respExc
);

	import mmuPkg::*;

	logic     mmuEn;
	logic     usDeny;                               // User access to a supervisor page
	noRwx_t   nextNoRwx;
	excCode_t nextExc;

	// Both ISR bits switch checking off inside interrupt handlers
	assign mmuEn  = lookMmcr[`MMCR_EN] && !(lookSr[`SR_ISR_A] && lookSr[`SR_ISR_B]);
	assign usDeny = lookAcc[`BIT_NU] && !lookSr[`SR_SUPER];

	always_comb
	begin
		nextNoRwx = '0;
		nextExc   = `EXC_NONE;

		if (krEnA)
		begin
			case (lookAcc[`ACC_KRMODE])
				3'd0:
				begin
					nextNoRwx[`BIT_NX] = 1'b1;      // Deny all
					nextNoRwx[`BIT_NW] = 1'b1;
					nextNoRwx[`BIT_NR] = 1'b1;
				end
				3'd1:
				begin
					nextNoRwx[`BIT_NX] = !krAccFl[`KR_X];
					nextNoRwx[`BIT_NW] = !krAccFl[`KR_W];
					nextNoRwx[`BIT_NR] = !krAccFl[`KR_R];
				end
				3'd2:
					nextExc = `EXC_ACCESS;
				3'd3:
				begin
					// Trap on the operation itself instead of masking
					if (lookOpm[`OPM_WR] && !krAccFl[`KR_W])
						nextExc = `EXC_ACCESS;
					if (lookOpm[`OPM_RD] && !krAccFl[`KR_R])
						nextExc = `EXC_ACCESS;
				end
				default:
					nextExc = `EXC_ACCESS;          // Reserved modes
			endcase
		end

		// Base bits add to the keyring result
		if (usDeny)
			nextNoRwx[`BIT_NU] = 1'b1;
		if (lookAcc[`BIT_NX] || usDeny)
			nextNoRwx[`BIT_NX] = 1'b1;
		if (lookAcc[`BIT_NW] || usDeny)
			nextNoRwx[`BIT_NW] = 1'b1;
		if (lookAcc[`BIT_NR] || usDeny)
			nextNoRwx[`BIT_NR] = 1'b1;

		if (nextExc != `EXC_NONE)
			nextNoRwx = '0;

		if (!lookHit)
		begin
			nextNoRwx = '0;
			nextExc   = `EXC_TLBMISS;
		end

		// Disabled MMU overrides everything, misses included
		if (!mmuEn)
		begin
			nextNoRwx = '0;
			nextExc   = `EXC_NONE;
		end
	end

	// Stage 2
	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			respValid <= 1'b0;
			respNoRwx <= '0;
			respExc   <= `EXC_NONE;
		end
		else
		begin
			respValid <= lookValid;
			respNoRwx <= lookValid ? nextNoRwx : noRwx_t'(0);   // Zero between responses
			respExc   <= lookValid ? nextExc : excCode_t'(`EXC_NONE);
		end
	end

endmodule

/* rtl/mmuTop.sv */
// Response comes exactly two cycles after reqValid with no back-pressure; loads take one edge
`timescale 1ns/1ns
`include "mmu_consts.svh"

module mmuTop
(
	input  logic                               clock,
	input  logic                               rst,

	input  logic                               loadValid,
	input  logic [$clog2(`TLB_ENTRIES)-1:0]    loadIndex,
	input  mmuPkg::vpn_t                       loadVpn,
	input  mmuPkg::accMode_t                   loadAcc,

	input  logic                               reqValid,
	input  mmuPkg::vpn_t                       reqVpn,
	input  logic [7:0]                         reqOpm,
	input  mmuPkg::keyring_t                   krr,
	input  logic [63:0]                        sr,
	input  logic [63:0]                        mmcr,

	output logic                               respValid,
	output mmuPkg::noRwx_t                     respNoRwx,
	output mmuPkg::excCode_t                   respExc
);

	import mmuPkg::*;

	logic        lookValid;
	logic        lookHit;
	accMode_t    lookAcc;
	keyring_t    lookKrr;
	logic [63:0] lookSr;
	logic [63:0] lookMmcr;
	logic [7:0]  lookOpm;
	krAcc_t      krAccFl;                           // Selected X/W/R field
	logic        krEnA;

	tlbArray uTlb
	(
		.clock     (clock),
		.rst       (rst),
		.loadValid (loadValid),
		.loadIndex (loadIndex),
		.loadVpn   (loadVpn),
		.loadAcc   (loadAcc),
		.reqValid  (reqValid),
		.reqVpn    (reqVpn),
		.reqOpm    (reqOpm),
		.krr       (krr),
		.sr        (sr),
		.mmcr      (mmcr),
		.lookValid (lookValid),
		.lookHit   (lookHit),
		.lookAcc   (lookAcc),
		.lookKrr   (lookKrr),
		.lookSr    (lookSr),
		.lookMmcr  (lookMmcr),
		.lookOpm   (lookOpm)
	);

	keyringMatch uKeyring
	(
		.acc     (lookAcc),
		.krr     (lookKrr),
		.krAccFl (krAccFl),
		.krEnA   (krEnA)
	);

	accessCheck uCheck
	(
		.clock     (clock),
		.rst       (rst),
		.lookValid (lookValid),
		.lookHit   (lookHit),
		.lookAcc   (lookAcc),
		.lookSr    (lookSr),
		.lookMmcr  (lookMmcr),
		.lookOpm   (lookOpm),
		.krAccFl   (krAccFl),
		.krEnA     (krEnA),
		.respValid (respValid),
		.respNoRwx (respNoRwx),
		.respExc   (respExc)
	);

endmodule

/* dv/clockGen.sv */
// Free-running 8 ns clock; reset is high from time zero for three rising edges
`timescale 1ns/1ns

module clockGen
(
	output logic clock,
	output logic rst
);

	initial
	begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	initial
	begin
		rst = 1'b1;
		repeat (3) @(posedge clock);
		@(negedge clock);                           // Release away from the active edge
		rst = 1'b0;
	end

endmodule

/* dv/mmu_checker.sv */
// Bound into mmuTop as uChecker; assumes reqValid stays low while rst is high
`timescale 1ns/1ns

module mmuChecker
(
	input logic        clock,
	input logic        rst,
	input logic        reqValid,
	input logic        respValid,
	input logic [5:0]  respNoRwx,
	input logic [15:0] respExc
);

	int failCount = 0;                              // Read by the testbench

	latencyTwo: assert property (@(posedge clock) disable iff (rst)
		respValid == $past(reqValid, 2))
	else
	begin
		failCount++;
		$error("respValid does not follow reqValid by two cycles");
	end

	quietInReset: assert property (@(posedge clock) rst |=> !respValid)
	else
	begin
		failCount++;
		$error("respValid high during reset");
	end

	// Hold and Resv never used
	spareBitsZero: assert property (@(posedge clock) disable iff (rst)
		respNoRwx[5:4] == 2'b00)
	else
	begin
		failCount++;
		$error("respNoRwx bits 5 or 4 set");
	end

	excClearsMask: assert property (@(posedge clock) disable iff (rst)
		(respExc != 16'h0000) |-> (respNoRwx == 6'h00))
	else
	begin
		failCount++;
		$error("Exception reported together with a non-zero mask");
	end

endmodule

bind mmuTop mmuChecker uChecker
(
	.clock     (clock),
	.rst       (rst),
	.reqValid  (reqValid),
	.respValid (respValid),
	.respNoRwx (respNoRwx),
	.respExc   (respExc)
);

/* dv/mmuTb.sv */
// Directed cases, then LFSR-driven traffic; relies on the bound checker instance DUT.uChecker
`timescale 1ns/1ns
`include "mmu_consts.svh"

module mmuTb;

	import mmuPkg::*;

	localparam int          numRand  = 2000;
	localparam int          numFixed = 120;     // Reset and directed cycles, rounded up
	localparam logic [63:0] srSuper  = 64'h4000_0000;
	localparam logic [63:0] srIsr    = 64'h3000_0000;
	localparam logic [63:0] mmcrOn   = 64'h1;
	localparam keyring_t    krOther  = 64'h0000_0000_0000_0801;     // Key A of a foreign group
	localparam keyring_t    krGroupC = 64'h0000_1401_0000_0801;     // Group match in key C only
	localparam keyring_t    krUserD  = 64'h1433_1401_0000_0801;     // Full match in key D

	logic        clock;
	logic        rst;
	logic        loadValid;
	logic [1:0]  loadIndex;
	vpn_t        loadVpn;
	accMode_t    loadAcc;
	logic        reqValid;
	vpn_t        reqVpn;
	logic [7:0]  reqOpm;
	keyring_t    krr;
	logic [63:0] sr;
	logic [63:0] mmcr;
	logic        respValid;
	noRwx_t      respNoRwx;
	excCode_t    respExc;

	logic [3:0]  mValid;                            // TB copy of the TLB
	vpn_t        mVpn [4];
	accMode_t    mAcc [4];
	logic [21:0] expQ [$];                          // {mask, exception}
	logic [21:0] expected;
	logic [31:0] lfsr;

	clockGen uClk (.clock(clock), .rst(rst));

	mmuTop DUT (.*);

	task automatic failRun(input string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1, "Simulation stopped on error");
	endtask

	task automatic checkValue(input string what, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp)
			failRun($sformatf("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp));
	endtask

	// Galois LFSR, one step per bit
	function automatic logic [31:0] takeBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic [15:0] randKey();
		if (takeBits(2) == 0)
			return 16'h0000;                        // Empty slot
		return {4'd0, 2'(takeBits(2)), 8'd0, 2'(takeBits(2))};
	endfunction

	function automatic accMode_t randAcc();
		return {4'd0, 2'(takeBits(2)), 8'd0, 2'(takeBits(2)), 16'(takeBits(16))};
	endfunction

	function automatic logic [21:0] refResult(input logic hit, input accMode_t acc,
		input keyring_t kr, input logic [63:0] s, input logic [63:0] m, input logic [7:0] op);
		logic [15:0] vugid;
		logic [15:0] key;
		logic        grpHit;
		logic        usrHit;
		logic [2:0]  grant;
		logic [5:0]  mask;
		logic [15:0] exc;
		vugid  = acc[`ACC_VUGID];
		grpHit = 1'b0;
		usrHit = 1'b0;
		mask   = '0;
		exc    = `EXC_NONE;
		if (!m[`MMCR_EN] || (s[`SR_ISR_A] && s[`SR_ISR_B]))
			return {6'd0, `EXC_NONE};
		if (!hit)
			return {6'd0, `EXC_TLBMISS};
		for (int k = 0; k < 4; k++)
		begin
			key = kr[k*16 +: 16];
			grpHit |= (key != 0) && (key[15:10] == vugid[15:10]);
			usrHit |= (key != 0) && (key == vugid);     // Group and user both equal
		end
		grant = usrHit ? acc[`ACC_USER] : (grpHit ? acc[`ACC_GROUP] : acc[`ACC_OTHER]);
		if (kr[15:0] != 0)
		begin
			case (acc[`ACC_KRMODE])
				3'd0: mask[2:0] = 3'b111;
				3'd1: mask[2:0] = ~grant;
				3'd3:
				begin
					if ((op[`OPM_WR] && !grant[1]) || (op[`OPM_RD] && !grant[0]))
						exc = `EXC_ACCESS;
				end
				default: exc = `EXC_ACCESS;
			endcase
		end
		if (acc[`BIT_NU] && !s[`SR_SUPER])
			mask[3:0] = 4'hF;                       // User on a supervisor page
		mask[2:0] = mask[2:0] | acc[2:0];
		if (exc != `EXC_NONE)
			mask = '0;
		return {mask, exc};
	endfunction

	task automatic nextCycle();
		@(negedge clock);
		loadValid = 1'b0;
		reqValid  = 1'b0;
	endtask

	task automatic loadEntry(input logic [1:0] idx, input vpn_t vpn, input accMode_t acc);
		loadValid   = 1'b1;
		loadIndex   = idx;
		loadVpn     = vpn;
		loadAcc     = acc;
		mValid[idx] = 1'b1;
		mVpn[idx]   = vpn;
		mAcc[idx]   = acc;
	endtask

	// Call before a same-cycle loadEntry so the model still holds the old contents
	task automatic sendRequest(input vpn_t vpn, input logic [7:0] op, input keyring_t kr,
		input logic [63:0] s, input logic [63:0] m);
		logic     hit;
		accMode_t acc;
		hit = 1'b0;
		acc = '0;
		for (int i = 0; i < 4; i++)
		begin
			if (!hit && mValid[i] && (mVpn[i] == vpn))
			begin
				hit = 1'b1;                         // Lowest index wins
				acc = mAcc[i];
			end
		end
		reqValid = 1'b1;
		reqVpn   = vpn;
		reqOpm   = op;
		krr      = kr;
		sr       = s;
		mmcr     = m;
		expQ.push_back(refResult(hit, acc, kr, s, m, op));
	endtask

	// Compare on the falling edge where outputs are settled
	always @(negedge clock)
	begin
		if (DUT.uChecker.failCount != 0)
			failRun("A bound assertion on the DUT failed");
		if (!rst && respValid)
		begin
			if (expQ.size() == 0)
				failRun("A response arrived with no request outstanding");
			else
			begin
				expected = expQ.pop_front();
				checkValue("respNoRwx", 16'(respNoRwx), 16'(expected[21:16]));
				checkValue("respExc", respExc, expected[15:0]);
			end
		end
	end

	initial
	begin
		#((numRand + numFixed) * 8 + 400);
		failRun("Timeout: the run did not finish in the expected time");
	end

	initial
	begin
		lfsr      = 32'h9cbe_82d6;
		mValid    = '0;
		loadValid = 1'b0;
		loadIndex = '0;
		loadVpn   = '0;
		loadAcc   = '0;
		reqValid  = 1'b0;
		reqVpn    = '0;
		reqOpm    = '0;
		krr       = '0;
		sr        = '0;
		mmcr      = '0;
		@(negedge rst);

		// MMU off by enable bit, then by both ISR bits
		nextCycle();
		sendRequest(20'h00abc, 8'h10, '0, '0, '0);
		nextCycle();
		sendRequest(20'h00abc, 8'h10, '0, srIsr, mmcrOn);
		nextCycle();
		sendRequest(20'h00abc, 8'h10, '0, '0, mmcrOn);          // Miss
		nextCycle();
		loadEntry(2'd0, 20'h00abc, 32'h0000_000D);              // NU, NX, NR
		nextCycle();
		sendRequest(20'h00abc, 8'h10, '0, '0, mmcrOn);
		nextCycle();
		sendRequest(20'h00abc, 8'h10, '0, srSuper, mmcrOn);

		// Field choice with keyring mode 1
		nextCycle();
		loadEntry(2'd1, 20'h00def, 32'h1433_2A10);
		nextCycle();
		sendRequest(20'h00def, 8'h10, krOther, srSuper, mmcrOn);
		nextCycle();
		sendRequest(20'h00def, 8'h10, krGroupC, srSuper, mmcrOn);
		nextCycle();
		sendRequest(20'h00def, 8'h10, krUserD, srSuper, mmcrOn);

		// Every keyring mode against read, write and both
		for (int md = 0; md < 8; md++)
		begin
			nextCycle();
			loadEntry(2'd2, 20'h00f00, {16'h1433, 16'h2A00 | 16'(md << 4)});
			for (int op = 1; op < 4; op++)
			begin
				nextCycle();
				sendRequest(20'h00f00, 8'(op << 4), krUserD, srSuper, mmcrOn);
				nextCycle();
				sendRequest(20'h00f00, 8'(op << 4), krGroupC, srSuper, mmcrOn);
			end
		end

		// Dense random traffic with loads mixed in
		for (int n = 0; n < numRand; n++)
		begin
			nextCycle();
			if (takeBits(3) != 0)
				sendRequest(vpn_t'(takeBits(3)), {2'b00, 2'(takeBits(2)), 4'h0},
					{randKey(), randKey(), randKey(), randKey()},
					{33'd0, 3'(takeBits(3)), 28'd0}, {63'd0, takeBits(2) != 0});
			if (takeBits(2) == 0)
				loadEntry(2'(takeBits(2)), vpn_t'(takeBits(3)), randAcc());
		end

		nextCycle();
		while (expQ.size() != 0)
			@(negedge clock);
		repeat (2) @(negedge clock);
		if (DUT.uChecker.failCount == 0)
		begin
			$display(">>> PASS");
			$finish;
		end
		else
			failRun("A bound assertion on the DUT failed");
	end

endmodule

/* sources.f */
+incdir+rtl
rtl/mmuPkg.sv
rtl/tlbArray.sv
rtl/keyringMatch.sv
rtl/accessCheck.sv
rtl/mmuTop.sv
dv/clockGen.sv
dv/mmu_checker.sv
dv/mmuTb.sv

/* Bender.yml */
package:
  name: mmu_page_check

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/mmuPkg.sv
      - rtl/tlbArray.sv
      - rtl/keyringMatch.sv
      - rtl/accessCheck.sv
      - rtl/mmuTop.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - dv/clockGen.sv
      - dv/mmu_checker.sv
      - dv/mmuTb.sv
